// File: cluster.f
source/cluster_pkg.sv
source/dcr_regs.sv
source/socket.sv
source/mem_arb.sv
source/gbar_unit.sv
source/cluster.sv
tb/cluster_checker.sv
tb/cluster_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := cluster_tb
FILELIST  := cluster.f
VFLAGS    := --timing --assert --timescale 1ns/1ps
OBJ_DIR   := obj_dir
PASS_MSG  := No errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: tb/cluster_tb.sv
module cluster_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import cluster_pkg::*;

    localparam int num_runs      = 200;
    localparam int timeout_limit = num_runs * num_sockets * 255 * 8;

    logic                                  clk = 1'b0;
    logic                                  rst;
    logic                                  dcr_write_valid;
    logic [dcr_addr_width-1:0]             dcr_write_addr;
    logic [dcr_data_width-1:0]             dcr_write_data;
    logic                                  mem_ack = 1'b0;
    logic [xlen-1:0]                       mem_rdata = '0;
    logic                                  mem_req;
    logic [addr_width-1:0]                 mem_addr;
    logic                                  busy;
    logic [num_sockets-1:0]                done;
    logic [num_sockets-1:0][xlen-1:0]      sum;
    int unsigned                           wait_left = 0;
    int                                    cycles = 0;

    cluster u_cluster (
        .clk             (clk),
        .rst             (rst),
        .dcr_write_valid (dcr_write_valid),
        .dcr_write_addr  (dcr_write_addr),
        .dcr_write_data  (dcr_write_data),
        .mem_ack         (mem_ack),
        .mem_rdata       (mem_rdata),
        .mem_req         (mem_req),
        .mem_addr        (mem_addr),
        .busy            (busy),
        .done            (done),
        .sum             (sum)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_limit) begin
            $display("Timeout: the cluster did not finish within %0d cycles", timeout_limit);
            $display("Errors found");
            $fatal(1, "simulation stopped by timeout");
        end
    end

    // Memory contents as a function of the word address
    function automatic logic [xlen-1:0] mem_word(input logic [addr_width-1:0] a);
        logic [xlen-1:0] wide;
        wide = xlen'(a);
        return wide * 32'h9e37 + (wide << 16);
    endfunction

    function automatic logic [xlen-1:0] block_sum(input logic [addr_width-1:0] base,
                                                  input logic [count_width-1:0] count);
        logic [xlen-1:0]       acc;
        logic [addr_width-1:0] a;
        acc = '0;
        a   = base;
        for (int k = 0; k < int'(count); k++) begin
            acc = acc + mem_word(a);
            a   = a + addr_width'(1);
        end
        return acc;
    endfunction

    function automatic logic [dcr_addr_width-1:0] unmapped_addr();
        logic [dcr_addr_width-1:0] a;
        a = dcr_addr_width'($urandom);
        if (a == dcr_start_addr || (a >= dcr_sock_begin && a < dcr_sock_end)) begin
            a = a ^ 8'h40;
        end
        return a;
    endfunction

    // Memory responder with 0 to 3 cycles of delay per request
    always @(posedge clk) begin
        if (rst) begin
            mem_ack   <= 1'b0;
            wait_left <= $urandom % 4;
        end else if (mem_req && !mem_ack) begin
            if (wait_left == 0) begin
                mem_ack   <= 1'b1;
                mem_rdata <= mem_word(mem_addr);
            end else begin
                wait_left <= wait_left - 1;
            end
        end else if (!mem_req && mem_ack) begin
            mem_ack   <= 1'b0;
            wait_left <= $urandom % 4;
        end
    end

    task automatic compare(input string name, input logic [xlen-1:0] exp,
                           input logic [xlen-1:0] act);
        if (exp !== act) begin
            $display("FAILED %s expected %h actual %h", name, exp, act);
            $display("Errors found");
            $fatal(1, "stopping on first mismatch");
        end
    endtask

    task automatic dcr_write(input logic [dcr_addr_width-1:0] a,
                             input logic [dcr_data_width-1:0] d);
        @(posedge clk);
        dcr_write_valid <= 1'b1;
        dcr_write_addr  <= a;
        dcr_write_data  <= d;
        @(posedge clk);
        dcr_write_valid <= 1'b0;
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst <= 1'b1;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        compare("reset mem_req", '0, xlen'(mem_req));
        compare("reset busy", '0, xlen'(busy));
        compare("reset done", '0, xlen'(done));
        for (int i = 0; i < num_sockets; i++) begin
            compare($sformatf("reset sum %0d", i), '0, sum[i]);
        end
    endtask

    task automatic run_once(input int r);
        logic [num_sockets-1:0] mask;
        logic [addr_width-1:0]  base [num_sockets];
        logic [count_width-1:0] count [num_sockets];
        logic                   long_run;
        apply_reset();
        case (r % 3)
            0: mask = num_sockets'(1) << ($urandom % num_sockets);
            1: mask = '1;
            default: mask = num_sockets'($urandom % 15 + 1);
        endcase
        long_run = 1'b0;
        for (int i = 0; i < num_sockets; i++) begin
            base[i]  = addr_width'($urandom);
            count[i] = count_width'($urandom);
            if (r % 5 == 0 && i == r % num_sockets) begin
                count[i] = '0;
            end
            if (mask[i] && count[i] >= 16) begin
                long_run = 1'b1;
            end
            dcr_write(dcr_sock_begin + dcr_addr_width'(2 * i), dcr_data_width'(base[i]));
            dcr_write(dcr_sock_begin + dcr_addr_width'(2 * i + 1), dcr_data_width'(count[i]));
        end
        dcr_write(unmapped_addr(), $urandom);
        dcr_write(unmapped_addr(), $urandom);
        dcr_write(dcr_start_addr, dcr_data_width'(mask));
        // Stray writes land while the sockets are still running
        if (long_run) begin
            dcr_write(unmapped_addr(), $urandom);
            dcr_write(dcr_start_addr, '1);
        end
        do begin
            @(posedge clk);
            if (done == '0) begin
                compare($sformatf("run %0d busy before done", r), 1, xlen'(busy));
            end
        end while (done == '0);
        compare($sformatf("run %0d done bits", r), xlen'(mask), xlen'(done));
        compare($sformatf("run %0d busy at done", r), '0, xlen'(busy));
        for (int i = 0; i < num_sockets; i++) begin
            compare($sformatf("run %0d socket %0d sum", r, i),
                    mask[i] ? block_sum(base[i], count[i]) : '0, sum[i]);
        end
    endtask

    initial begin
        rst             = 1'b1;
        dcr_write_valid = 1'b0;
        dcr_write_addr  = '0;
        dcr_write_data  = '0;
        void'($urandom(32'h5aac));
        for (int r = 0; r < num_runs; r++) begin
            run_once(r);
        end
        $display("No errors");
        $finish;
    end

endmodule

// File: tb/cluster_checker.sv
module cluster_checker (
    input logic                                clk,
    input logic                                rst,
    input logic                                mem_req,
    input logic                                mem_ack,
    input logic [cluster_pkg::addr_width-1:0]  mem_addr,
    input logic                                busy,
    input logic [cluster_pkg::num_sockets-1:0] done
);
    timeunit 1ns;
    timeprecision 1ps;

    // Address held until the responder acknowledges
    addr_stable: assert property (@(posedge clk) disable iff (rst)
        (mem_req && !mem_ack) |=> $stable(mem_addr))
        else $error("mem_addr changed during an open request");

    req_after_ack_low: assert property (@(posedge clk) disable iff (rst)
        $rose(mem_req) |-> !mem_ack)
        else $error("mem_req rose while mem_ack was still high");

    done_not_busy: assert property (@(posedge clk) disable iff (rst)
        !(busy && (done != '0)))
        else $error("a done bit is high while the cluster is busy");

endmodule

bind cluster cluster_checker u_cluster_checker (
    .clk      (clk),
    .rst      (rst),
    .mem_req  (mem_req),
    .mem_ack  (mem_ack),
    .mem_addr (mem_addr),
    .busy     (busy),
    .done     (done)
);

// File: source/cluster.sv
module cluster (
    input  logic                                               clk,
    input  logic                                               rst,
    input  logic                                               dcr_write_valid,
    input  logic [cluster_pkg::dcr_addr_width-1:0]             dcr_write_addr,
    input  logic [cluster_pkg::dcr_data_width-1:0]             dcr_write_data,
    input  logic                                               mem_ack,
    input  logic [cluster_pkg::xlen-1:0]                       mem_rdata,
    output logic                                               mem_req,
    output logic [cluster_pkg::addr_width-1:0]                 mem_addr,
    output logic                                               busy,
    output logic [cluster_pkg::num_sockets-1:0]                done,
    output logic [cluster_pkg::num_sockets-1:0][cluster_pkg::xlen-1:0] sum
);
    import cluster_pkg::*;

    logic [num_sockets-1:0][addr_width-1:0]  sock_base;
    logic [num_sockets-1:0][count_width-1:0] sock_count;
    logic [num_sockets-1:0]                  sock_start;
    logic [num_sockets-1:0]                  active_mask;
    logic [num_sockets-1:0]                  sock_req;
    logic [num_sockets-1:0][addr_width-1:0]  sock_addr;
    logic [num_sockets-1:0]                  sock_ack;
    logic [xlen-1:0]                         sock_rdata;
    logic [num_sockets-1:0]                  arrive;
    logic [num_sockets-1:0]                  sock_busy;
    logic                                    bar_release;

    assign busy = |sock_busy;

    dcr_regs u_dcr_regs (
        .clk             (clk),
        .rst             (rst),
        .dcr_write_valid (dcr_write_valid),
        .dcr_write_addr  (dcr_write_addr),
        .dcr_write_data  (dcr_write_data),
        .busy            (busy),
        .sock_base       (sock_base),
        .sock_count      (sock_count),
        .sock_start      (sock_start),
        .active_mask     (active_mask)
    );

    for (genvar i = 0; i < num_sockets; i++) begin : g_socket
        socket u_socket (
            .clk         (clk),
            .rst         (rst),
            .start       (sock_start[i]),
            .base        (sock_base[i]),
            .count       (sock_count[i]),
            .sock_ack    (sock_ack[i]),
            .sock_rdata  (sock_rdata),
            .bar_release (bar_release),
            .sock_req    (sock_req[i]),
            .sock_addr   (sock_addr[i]),
            .arrive      (arrive[i]),
            .busy        (sock_busy[i]),
            .done        (done[i]),
            .sum         (sum[i])
        );
    end

    mem_arb u_mem_arb (
        .clk        (clk),
        .rst        (rst),
        .sock_req   (sock_req),
        .sock_addr  (sock_addr),
        .mem_ack    (mem_ack),
        .mem_rdata  (mem_rdata),
        .sock_ack   (sock_ack),
        .sock_rdata (sock_rdata),
        .mem_req    (mem_req),
        .mem_addr   (mem_addr)
    );

    gbar_unit u_gbar_unit (
        .clk         (clk),
        .rst         (rst),
        .arrive      (arrive),
        .active_mask (active_mask),
        .bar_release (bar_release)
    );

endmodule

// File: source/gbar_unit.sv
module gbar_unit (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [cluster_pkg::num_sockets-1:0] arrive,
    input  logic [cluster_pkg::num_sockets-1:0] active_mask,
    output logic                                bar_release
);
    import cluster_pkg::*;

    logic [num_sockets-1:0] arrived;
    logic                   all_in;
    logic                   armed;

    assign arrived = arrive & active_mask;
    assign all_in  = (active_mask != '0) && (arrived == active_mask);

    always_ff @(posedge clk) begin
        if (rst) begin
            bar_release <= 1'b0;
            armed       <= 1'b1;
        end else begin
            bar_release <= all_in && armed;
            if (all_in && armed) begin
                armed <= 1'b0;
            end else if (arrive == '0) begin
                // Re-arm once every socket has left the barrier
                armed <= 1'b1;
            end
        end
    end

endmodule

// File: source/mem_arb.sv
module mem_arb (
    input  logic                                                 clk,
    input  logic                                                 rst,
    input  logic [cluster_pkg::num_sockets-1:0]                  sock_req,
    input  logic [cluster_pkg::num_sockets-1:0][cluster_pkg::addr_width-1:0] sock_addr,
    input  logic                                                 mem_ack,
    input  logic [cluster_pkg::xlen-1:0]                         mem_rdata,
    output logic [cluster_pkg::num_sockets-1:0]                  sock_ack,
    output logic [cluster_pkg::xlen-1:0]                         sock_rdata,
    output logic                                                 mem_req,
    output logic [cluster_pkg::addr_width-1:0]                   mem_addr
);
    import cluster_pkg::*;

    logic                      grant_valid;
    logic [sock_idx_width-1:0] grant_idx;
    logic [sock_idx_width-1:0] rr_ptr;
    logic [sock_idx_width-1:0] cand;
    logic [sock_idx_width-1:0] pick_idx;
    logic                      pick_valid;
    logic                      grant_done;

    // First requester at or after rr_ptr; index wraps with its width
    always_comb begin
        pick_valid = 1'b0;
        pick_idx   = rr_ptr;
        cand       = rr_ptr;
        for (int k = num_sockets - 1; k >= 0; k--) begin
            cand = rr_ptr + sock_idx_width'(k);
            if (sock_req[cand]) begin
                pick_valid = 1'b1;
                pick_idx   = cand;
            end
        end
    end

    // Handshake fully closed on both sides
    assign grant_done = grant_valid && !sock_req[grant_idx] && !mem_ack;

    always_ff @(posedge clk) begin
        if (rst) begin
            grant_valid <= 1'b0;
            grant_idx   <= '0;
            rr_ptr      <= '0;
        end else if (grant_done) begin
            grant_valid <= 1'b0;
            rr_ptr      <= grant_idx + sock_idx_width'(1);
        end else if (!grant_valid && pick_valid) begin
            grant_valid <= 1'b1;
            grant_idx   <= pick_idx;
        end
    end

    assign mem_req    = grant_valid && sock_req[grant_idx];
    assign mem_addr   = sock_addr[grant_idx];
    assign sock_rdata = mem_rdata;

    always_comb begin
        sock_ack            = '0;
        sock_ack[grant_idx] = grant_valid && mem_ack;
    end

endmodule

// File: source/socket.sv
module socket (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 start,
    input  logic [cluster_pkg::addr_width-1:0]   base,
    input  logic [cluster_pkg::count_width-1:0]  count,
    input  logic                                 sock_ack,
    input  logic [cluster_pkg::xlen-1:0]         sock_rdata,
    input  logic                                 bar_release,
    output logic                                 sock_req,
    output logic [cluster_pkg::addr_width-1:0]   sock_addr,
    output logic                                 arrive,
    output logic                                 busy,
    output logic                                 done,
    output logic [cluster_pkg::xlen-1:0]         sum
);
    import cluster_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_req,
        st_ack_low,
        st_bar,
        st_done
    } state_t;

    state_t                 state;
    logic [addr_width-1:0]  addr;
    logic [count_width-1:0] remaining;
    logic                   launch;
    logic                   word_in;

    assign launch  = start && ((state == st_idle) || (state == st_done));
    assign word_in = (state == st_req) && sock_ack;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
            sum   <= '0;
        end else begin
            case (state)
                st_idle, st_done: begin
                    if (launch) begin
                        sum   <= '0;
                        // Empty block joins the barrier right away
                        state <= (count == '0) ? st_bar : st_req;
                    end
                end
                st_req: begin
                    if (sock_ack) begin
                        sum   <= sum + sock_rdata;
                        state <= st_ack_low;
                    end
                end
                st_ack_low: begin
                    // Next req only once ack is back low
                    if (!sock_ack) begin
                        state <= (remaining == '0) ? st_bar : st_req;
                    end
                end
                st_bar: begin
                    if (bar_release) begin
                        state <= st_done;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Address walk wraps at addr_width
    always_ff @(posedge clk) begin
        if (launch) begin
            addr      <= base;
            remaining <= count;
        end else if (word_in) begin
            addr      <= addr + addr_width'(1);
            remaining <= remaining - count_width'(1);
        end
    end

    assign sock_req  = (state == st_req);
    assign sock_addr = addr;
    assign arrive    = (state == st_bar);
    assign done      = (state == st_done);

    // Busy already covers the start pulse cycle
    assign busy = start
               || (state == st_req)
               || (state == st_ack_low)
               || (state == st_bar);

endmodule

// File: source/dcr_regs.sv
module dcr_regs (
    input  logic                                                  clk,
    input  logic                                                  rst,
    input  logic                                                  dcr_write_valid,
    input  logic [cluster_pkg::dcr_addr_width-1:0]                dcr_write_addr,
    input  logic [cluster_pkg::dcr_data_width-1:0]                dcr_write_data,
    input  logic                                                  busy,
    output logic [cluster_pkg::num_sockets-1:0][cluster_pkg::addr_width-1:0]  sock_base,
    output logic [cluster_pkg::num_sockets-1:0][cluster_pkg::count_width-1:0] sock_count,
    output logic [cluster_pkg::num_sockets-1:0]                   sock_start,
    output logic [cluster_pkg::num_sockets-1:0]                   active_mask
);
    import cluster_pkg::*;

    logic                      sock_hit;
    logic                      start_hit;
    logic [sock_idx_width-1:0] sock_sel;

    assign sock_hit = dcr_write_valid
                   && (dcr_write_addr >= dcr_sock_begin)
                   && (dcr_write_addr < dcr_sock_end);

    // Two registers per socket
    assign sock_sel = sock_idx_width'((dcr_write_addr - dcr_sock_begin) >> 1);

    // Start is dropped while any socket still runs
    assign start_hit = dcr_write_valid && (dcr_write_addr == dcr_start_addr) && !busy;

    always_ff @(posedge clk) begin
        if (sock_hit) begin
            if (dcr_write_addr[0]) begin
                sock_count[sock_sel] <= dcr_write_data[count_width-1:0];
            end else begin
                sock_base[sock_sel] <= dcr_write_data[addr_width-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sock_start  <= '0;
            active_mask <= '0;
        end else begin
            sock_start <= start_hit ? dcr_write_data[num_sockets-1:0] : '0;
            if (start_hit) begin
                active_mask <= dcr_write_data[num_sockets-1:0];
            end
        end
    end

endmodule

// File: source/cluster_pkg.sv
package cluster_pkg;

    // Cluster sizing
    localparam int num_sockets    = 4;
    localparam int sock_idx_width = $clog2(num_sockets);

    // Data and memory widths
    localparam int xlen           = 32;
    localparam int addr_width     = 16;
    localparam int count_width    = 8;

    // DCR bus widths
    localparam int dcr_addr_width = 8;
    localparam int dcr_data_width = 32;

    // DCR address map
    localparam logic [dcr_addr_width-1:0] dcr_start_addr = 8'h08;

    // Base of socket i at begin + 2i, its count right after
    localparam logic [dcr_addr_width-1:0] dcr_sock_begin = 8'h10;
    localparam logic [dcr_addr_width-1:0] dcr_sock_end   = 8'h18;

endpackage
